/* design/arith_pkg.sv */
// Arithmetic unit package
// Opcode, funct and ALU function encodings plus the structs that carry
// requests, decoded operations and results through the pipeline

package arith_pkg;

    localparam int XLEN      = 32;
    localparam int DEF_TAG_W = 5;  // Destination tag width carried in every struct

    // Major opcodes handled by the unit
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // Shared by the OP and OP-IMM groups
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_JALR    = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;  // ADD, SRL and all other base forms
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_PASS = 4'd10  // Result is operand 2
    } alu_func_e;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [31:0]          inst;
        logic [XLEN-1:0]      rs1_value;
        logic [XLEN-1:0]      rs2_value;
        logic [DEF_TAG_W-1:0] tag;
    } arith_req_t;

    typedef struct packed {
        alu_func_e            func;
        logic [XLEN-1:0]      op1;
        logic [XLEN-1:0]      op2;
        logic                 illegal;
        logic [DEF_TAG_W-1:0] tag;
    } arith_op_t;

    typedef struct packed {
        logic [XLEN-1:0]      value;
        logic                 illegal;
        logic [DEF_TAG_W-1:0] tag;
    } arith_wb_t;

endpackage

/* design/arith_decode.sv */
// Arithmetic unit decode
// Picks the ALU function and both operands for OP, OP-IMM, LUI, AUIPC,
// JAL and JALR, and flags every other encoding as illegal

`timescale 1ns/10ps

module arith_decode (
    input  arith_pkg::arith_req_t req_i,
    output arith_pkg::arith_op_t  op_o
);
    import arith_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] shamt_imm;
    logic [XLEN-1:0] shamt_reg;

    alu_func_e       func;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic            bad;

    assign opcode = req_i.inst[6:0];
    assign funct3 = req_i.inst[14:12];
    assign funct7 = req_i.inst[31:25];

    assign imm_i     = {{20{req_i.inst[31]}}, req_i.inst[31:20]};
    assign imm_u     = {req_i.inst[31:12], 12'b0};
    assign shamt_imm = {27'b0, req_i.inst[24:20]};
    assign shamt_reg = {27'b0, req_i.rs2_value[4:0]};  // Only the low five bits of rs2 shift

    always_comb begin
        func = ALU_PASS;
        op1  = req_i.rs1_value;
        op2  = '0;
        bad  = 1'b0;

        case (opcode)
            OPC_OP_IMM: begin
                op2 = imm_i;  // Set-less-than compares against the full immediate
                case (funct3)
                    F3_ADD_SUB: func = ALU_ADD;
                    F3_SLT:     func = ALU_SLT;
                    F3_SLTU:    func = ALU_SLTU;
                    F3_XOR:     func = ALU_XOR;
                    F3_OR:      func = ALU_OR;
                    F3_AND:     func = ALU_AND;
                    F3_SLL: begin
                        func = ALU_SLL;
                        op2  = shamt_imm;
                        bad  = (funct7 != F7_BASE);
                    end
                    F3_SR: begin
                        op2 = shamt_imm;
                        if (funct7 == F7_BASE) begin
                            func = ALU_SRL;
                        end else if (funct7 == F7_ALT) begin
                            func = ALU_SRA;
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    default: bad = 1'b1;
                endcase
            end
            OPC_OP: begin
                op2 = req_i.rs2_value;
                // SUB and SRA are the only forms with the alternate funct7
                case (funct3)
                    F3_ADD_SUB: begin
                        if (funct7 == F7_BASE) begin
                            func = ALU_ADD;
                        end else if (funct7 == F7_ALT) begin
                            func = ALU_SUB;
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    F3_SR: begin
                        op2 = shamt_reg;
                        if (funct7 == F7_BASE) begin
                            func = ALU_SRL;
                        end else if (funct7 == F7_ALT) begin
                            func = ALU_SRA;
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    F3_SLL: begin
                        func = ALU_SLL;
                        op2  = shamt_reg;
                        bad  = (funct7 != F7_BASE);
                    end
                    F3_SLT:  func = ALU_SLT;
                    F3_SLTU: func = ALU_SLTU;
                    F3_XOR:  func = ALU_XOR;
                    F3_OR:   func = ALU_OR;
                    F3_AND:  func = ALU_AND;
                    default: bad = 1'b1;
                endcase
                if (funct3 != F3_ADD_SUB && funct3 != F3_SR && funct7 != F7_BASE) begin
                    bad = 1'b1;
                end
            end
            OPC_LUI: begin
                func = ALU_PASS;
                op2  = imm_u;
            end
            OPC_AUIPC: begin
                func = ALU_ADD;
                op1  = req_i.pc;
                op2  = imm_u;
            end
            OPC_JAL: begin
                func = ALU_ADD;  // Link address only, the target is formed elsewhere
                op1  = req_i.pc;
                op2  = 32'd4;
            end
            OPC_JALR: begin
                func = ALU_ADD;
                op1  = req_i.pc;
                op2  = 32'd4;
                bad  = (funct3 != F3_JALR);
            end
            default: bad = 1'b1;
        endcase
    end

    // An illegal encoding leaves as PASS of zero so the ALU result is clean
    assign op_o.func    = bad ? ALU_PASS : func;
    assign op_o.op1     = bad ? '0 : op1;
    assign op_o.op2     = bad ? '0 : op2;
    assign op_o.illegal = bad;
    assign op_o.tag     = req_i.tag;

endmodule

/* design/arith_alu.sv */
// Arithmetic unit execute stage
// Computes the writeback value of one decoded operation in a single
// combinational pass

`timescale 1ns/10ps

module arith_alu (
    input  arith_pkg::arith_op_t op_i,
    output arith_pkg::arith_wb_t wb_o
);
    import arith_pkg::*;

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [4:0]      shamt;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [XLEN-1:0] result;

    assign op1   = op_i.op1;
    assign op2   = op_i.op2;
    assign shamt = op2[4:0];

    assign sum  = op1 + op2;
    assign diff = op1 - op2;

    assign lt_signed   = $signed(op1) < $signed(op2);
    assign lt_unsigned = op1 < op2;

    always_comb begin
        case (op_i.func)
            ALU_ADD: begin
                result = sum;
            end
            ALU_SUB: begin
                result = diff;
            end
            ALU_SLL: begin
                result = op1 << shamt;
            end
            ALU_SLT: begin
                result = {31'b0, lt_signed};
            end
            ALU_SLTU: begin
                result = {31'b0, lt_unsigned};
            end
            ALU_XOR: begin
                result = op1 ^ op2;
            end
            ALU_SRL: begin
                result = op1 >> shamt;
            end
            ALU_SRA: begin
                result = $unsigned($signed(op1) >>> shamt);  // Sign bit fills from the left
            end
            ALU_OR: begin
                result = op1 | op2;
            end
            ALU_AND: begin
                result = op1 & op2;
            end
            ALU_PASS: begin
                result = op2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Illegal operations always write zero
    assign wb_o.value   = op_i.illegal ? '0 : result;
    assign wb_o.illegal = op_i.illegal;
    assign wb_o.tag     = op_i.tag;

endmodule

/* design/arith_stage.sv */
// Pipeline register slice
// Holds one payload with its valid bit between two valid/ready ports
// and accepts a new entry in the same cycle the old one leaves

`timescale 1ns/10ps

module arith_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // Free when empty or when the current entry drains this cycle
    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_ready_o && in_valid_i) begin
            data_q <= in_data_i;  // Held unchanged while the consumer stalls
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

endmodule

/* design/arith_unit.sv */
// RV32I integer arithmetic unit
// Decode and operation register, then ALU and result register, giving
// a two cycle latency at one request per cycle

`timescale 1ns/10ps

module arith_unit #(
    parameter int TAG_W = arith_pkg::DEF_TAG_W
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  arith_pkg::arith_req_t req_i,

    output logic                  wb_valid_o,
    input  logic                  wb_ready_i,
    output arith_pkg::arith_wb_t  wb_o
);
    import arith_pkg::*;

    // The structs fix the tag width, so the top parameter has to agree
    if (TAG_W != DEF_TAG_W) begin : g_tag_w_check
        $error("TAG_W must equal arith_pkg::DEF_TAG_W");
    end

    arith_op_t op_d;
    arith_op_t op_q;
    logic      op_valid;
    logic      op_ready;
    arith_wb_t wb_d;

    arith_decode u_decode (
        .req_i (req_i),
        .op_o  (op_d)
    );

    arith_stage #(
        .payload_t (arith_op_t)
    ) u_op_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (req_valid_i),
        .in_ready_o  (req_ready_o),
        .in_data_i   (op_d),
        .out_valid_o (op_valid),
        .out_ready_i (op_ready),
        .out_data_o  (op_q)
    );

    arith_alu u_alu (
        .op_i (op_q),
        .wb_o (wb_d)
    );

    arith_stage #(
        .payload_t (arith_wb_t)
    ) u_wb_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (op_valid),
        .in_ready_o  (op_ready),
        .in_data_i   (wb_d),
        .out_valid_o (wb_valid_o),
        .out_ready_i (wb_ready_i),
        .out_data_o  (wb_o)
    );

endmodule

/* verif/arith_clkgen.sv */
// Testbench clock and reset
// 4 ns clock, reset held low for the first 16 cycles

`timescale 1ns/10ps

module arith_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        #1 rst_n_o = 1'b1;  // Released off the edge like all other stimulus
    end

endmodule

/* verif/arith_chk.sv */
// Handshake checker for the arithmetic unit
// Bound into the top level, watches the writeback port and issue ready

`timescale 1ns/10ps

module arith_chk (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 req_ready_o,
    input logic                 wb_valid_o,
    input logic                 wb_ready_i,
    input arith_pkg::arith_wb_t wb_o
);

    // A reset edge always leaves the result stage empty
    a_no_valid_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !wb_valid_o)
        else $error("wb_valid_o high after a reset cycle");

    a_wb_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && !wb_ready_i |=> $stable(wb_o))
        else $error("wb_o changed while stalled");

    a_wb_valid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && !wb_ready_i |=> wb_valid_o)
        else $error("wb_valid_o dropped before its handshake");

    a_ready_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> req_ready_o)
        else $error("req_ready_o low right after reset");

endmodule

/* verif/arith_tb.sv */
// Testbench for the RV32I arithmetic unit
// Random and directed instructions, reference model, in-order scoreboard

`timescale 1ns/10ps

module arith_tb;
    import arith_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    logic       req_ready;
    arith_req_t req;
    logic       wb_valid;
    logic       wb_ready;
    arith_wb_t  wb;

    arith_wb_t   exp_q[$];
    int          acc_q[$];
    arith_wb_t   exp_wb;
    int          acc_cycle;
    int          cycle;
    logic [31:0] rng_state;
    logic [4:0]  tag_cnt;
    string       test_name;
    logic        check_lat;
    logic        rand_ready;

    arith_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    arith_unit #(
        .TAG_W (5)
    ) i_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_i       (req),
        .wb_valid_o  (wb_valid),
        .wb_ready_i  (wb_ready),
        .wb_o        (wb)
    );

    bind arith_unit arith_chk u_chk (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_ready_o (req_ready_o),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_o        (wb_o)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Expected result straight from the RV32I rules
    function automatic arith_wb_t ref_arith(arith_req_t r);
        arith_wb_t   res;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic        bad;
        logic [31:0] v;
        opc   = r.inst[6:0];
        f3    = r.inst[14:12];
        f7    = r.inst[31:25];
        a     = r.rs1_value;
        imm_i = {{20{r.inst[31]}}, r.inst[31:20]};
        imm_u = {r.inst[31:12], 12'h000};
        bad   = 1'b0;
        v     = 32'h0;
        if (opc == 7'h33 || opc == 7'h13) begin
            b = (opc == 7'h33) ? r.rs2_value : imm_i;
            if (f3 == 3'd1 || f3 == 3'd5) begin
                b = (opc == 7'h33) ? {27'h0, r.rs2_value[4:0]} : {27'h0, r.inst[24:20]};
            end
            case (f3)
                3'd0: begin
                    if (opc == 7'h13 || f7 == 7'h00) v = a + b;
                    else if (f7 == 7'h20) v = a - b;
                    else bad = 1'b1;
                end
                3'd1: v = a << b[4:0];
                3'd2: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: v = (a < b) ? 32'd1 : 32'd0;
                3'd4: v = a ^ b;
                3'd5: begin
                    if (f7 == 7'h00) v = a >> b[4:0];
                    else if (f7 == 7'h20) v = $signed(a) >>> b[4:0];
                    else bad = 1'b1;
                end
                3'd6: v = a | b;
                default: v = a & b;
            endcase
            // Only SUB and SRA may use a non-zero funct7, immediates excepted
            if (f3 != 3'd0 && f3 != 3'd5 && f7 != 7'h00 && (opc == 7'h33 || f3 == 3'd1)) begin
                bad = 1'b1;
            end
        end else if (opc == 7'h37) begin
            v = imm_u;
        end else if (opc == 7'h17) begin
            v = r.pc + imm_u;
        end else if (opc == 7'h6f || (opc == 7'h67 && f3 == 3'd0)) begin
            v = r.pc + 32'd4;
        end else begin
            bad = 1'b1;
        end
        res.value   = bad ? 32'h0 : v;
        res.illegal = bad;
        res.tag     = r.tag;
        return res;
    endfunction

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_wb(string name, arith_wb_t exp, arith_wb_t act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %h illegal=%b tag=%0d actual %h illegal=%b tag=%0d",
                name, exp.value, exp.illegal, exp.tag, act.value, act.illegal, act.tag);
            stop_with_failure();
        end
    endtask

    task automatic check_latency(string name, int exp, int act);
        if (exp != act) begin
            $display("[FAIL] %s latency expected %0d actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    // The scoreboard samples on the rising edge where every input is settled
    always @(posedge clk) begin
        if (rst_n) begin
            if (req_valid && req_ready) begin
                exp_q.push_back(ref_arith(req));
                acc_q.push_back(cycle);
            end
            if (wb_valid && wb_ready) begin
                if (exp_q.size() == 0) begin
                    $display("A result came out with no request outstanding");
                    stop_with_failure();
                end else begin
                    exp_wb    = exp_q.pop_front();
                    acc_cycle = acc_q.pop_front();
                    check_wb(test_name, exp_wb, wb);
                    if (check_lat) check_latency(test_name, 2, cycle - acc_cycle);
                end
            end
        end
        cycle = cycle + 1;
    end

    always begin
        @(posedge clk);
        #1;
        if (rand_ready) wb_ready = next_rand() > 32'h6000_0000;  // Mostly ready
        else wb_ready = 1'b1;
    end

    // Called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send(logic [31:0] inst, logic [31:0] rs1, logic [31:0] rs2);
        int waited;
        req.pc        = next_rand() & 32'hffff_fffc;
        req.inst      = inst;
        req.rs1_value = rs1;
        req.rs2_value = rs2;
        req.tag       = tag_cnt;
        req_valid     = 1'b1;
        tag_cnt       = tag_cnt + 5'd1;
        waited        = 0;
        forever begin
            @(posedge clk);
            if (req_ready) break;
            waited++;
            if (waited > 100) begin
                $display("Request was never accepted in %s", test_name);
                stop_with_failure();
            end
        end
        #1 req_valid = 1'b0;
    endtask

    function automatic logic [31:0] r_inst(logic [6:0] f7, logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'h33};
    endfunction

    function automatic logic [31:0] i_inst(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc);
        return {imm, 5'd1, f3, 5'd3, opc};
    endfunction

    task automatic run_reg_ops(int n);
        logic [31:0] corners[5];
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        for (int i = 0; i < n; i++) begin
            f3 = 3'(next_rand() % 8);
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && next_rand() % 2 == 1) ? 7'h20 : 7'h00;
            a  = (i % 3 == 0) ? corners[3'(next_rand() % 5)] : next_rand();
            b  = (i % 4 == 0) ? corners[3'(next_rand() % 5)] : next_rand();
            send(r_inst(f7, f3), a, b);
        end
    endtask

    task automatic run_imm_ops(int n);
        logic [2:0]  f3;
        logic [11:0] imm;
        for (int i = 0; i < n; i++) begin
            f3  = 3'(next_rand() % 8);
            imm = 12'(next_rand());
            if (f3 == 3'd1) imm[11:5] = 7'h00;
            if (f3 == 3'd5) imm[11:5] = (next_rand() % 2 == 1) ? 7'h20 : 7'h00;
            send(i_inst(imm, f3, 7'h13), (i % 2 == 0) ? (next_rand() | 32'h8000_0000)
                                                      : next_rand(), 32'h0);
        end
    endtask

    initial begin
        int waited;
        rng_state  = 32'd22;
        tag_cnt    = '0;
        cycle      = 0;
        check_lat  = 1'b0;
        rand_ready = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        wb_ready   = 1'b1;
        test_name  = "reset";
        waited     = 0;
        while (!rst_n) begin
            @(posedge clk);
            waited++;
            if (waited > 100) begin
                $display("Reset was never released");
                stop_with_failure();
            end
        end
        @(posedge clk);
        #1;

        test_name = "reg_ops";
        run_reg_ops(200);
        test_name = "imm_ops";
        send(i_inst(12'hfff, 3'd2, 7'h13), 32'hffff_fffe, 32'h0);  // SLTI against -1
        send(i_inst(12'hfff, 3'd3, 7'h13), 32'h0000_0005, 32'h0);
        send(i_inst(12'h41f, 3'd5, 7'h13), 32'h8000_0000, 32'h0);  // SRAI by 31
        run_imm_ops(200);

        test_name = "upper_and_jumps";
        for (int i = 0; i < 20; i++) begin
            send({next_rand() & 32'hffff_f000} | 32'h0000_01b7, 32'h0, 32'h0);
            send({next_rand() & 32'hffff_f000} | 32'h0000_0197, 32'h0, 32'h0);
            send({next_rand() & 32'hffff_f000} | 32'h0000_01ef, 32'h0, 32'h0);
            send(i_inst(12'(next_rand()), 3'd0, 7'h67), next_rand(), 32'h0);
        end

        test_name = "illegal";
        send(i_inst(12'h123, 3'd2, 7'h03), 32'h1234_5678, 32'h0);  // A load
        send(r_inst(7'h01, 3'd0), 32'h5, 32'h7);                   // M extension MUL
        send(i_inst(12'h405, 3'd1, 7'h13), 32'h1, 32'h0);
        send(i_inst(12'h004, 3'd1, 7'h67), 32'h1, 32'h0);
        send(r_inst(7'h20, 3'd7), 32'hff, 32'h0f);

        test_name = "latency";
        check_lat = 1'b1;
        run_reg_ops(30);
        repeat (4) @(posedge clk);
        #1;
        check_lat = 1'b0;

        test_name  = "backpressure";
        rand_ready = 1'b1;
        for (int i = 0; i < 150; i++) begin
            if (i % 2 == 0) send(r_inst(7'h00, 3'd0), next_rand(), next_rand());
            else send(i_inst(12'(next_rand()), 3'd4, 7'h13), next_rand(), 32'h0);
            repeat (next_rand() % 3) begin
                @(posedge clk);
                #1;
            end
        end

        waited = 0;
        while (exp_q.size() != 0 && waited <= 500) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d results were still missing at the end of the run", exp_q.size());
            stop_with_failure();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* filelist.f */
design/arith_pkg.sv
design/arith_decode.sv
design/arith_alu.sv
design/arith_stage.sv
design/arith_unit.sv
verif/arith_clkgen.sv
verif/arith_chk.sv
verif/arith_tb.sv

/* Makefile */
# Verilator build and run for the RV32I arithmetic unit

VERILATOR ?= verilator
TOP       ?= arith_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The simulator exits non-zero on $fatal or a failing assertion
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
